/* files.f */
immu_pkg.sv
tlb_ram.sv
immu.sv
insn_mem.sv
fetch_top.sv
tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_immu

sources:
  - immu_pkg.sv
  - tlb_ram.sv
  - immu.sv
  - insn_mem.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch.sv

/* tb_fetch.sv */
// Directed testbench for the fetch path: plain, translated, miss, permission, stall and flush
`timescale 1ns/1ps

module tb_fetch import immu_pkg::*; ();

   localparam int clk_period   = 40;
   // Watchdog budget in fetches, times a margin in cycles
   localparam int fetch_budget = 40;
   localparam int margin       = 10;
   localparam int n_words      = 16;

   logic              clk;
   logic              rst_n;
   logic              cmd_valid;
   logic              cmd_ready;
   logic [addr_w-1:0] cmd_addr;
   logic              flush;
   logic              ibus_valid;
   logic              ibus_ready;
   logic [insn_w-1:0] ibus_dout;
   fetch_exc_t        exc;
   logic [addr_w-1:0] out_id;
   logic [addr_w-1:0] out_id_nxt;
   psr_t              psr;
   tlb_wr_t           tlbl_wr;
   tlb_wr_t           tlbh_wr;
   tlb_word_u         tlbl_rd;
   tlb_word_u         tlbh_rd;
   logic [data_w-1:0] immid;
   imem_wr_t          imem_wr;

   // Memory contents as loaded, and the expected address registers
   logic [insn_w-1:0] model [imem_depth];
   logic [addr_w-1:0] exp_id;
   logic [addr_w-1:0] exp_nxt;
   integer            seed;
   int                errors;
   int                checks;

   fetch_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial begin
      #(fetch_budget * margin * clk_period);
      $display("Timeout: the run did not finish within %0d clock periods", fetch_budget * margin);
      $display("STATUS: FAIL");
      $finish;
   end

   //////////////////////////////////////////////////
   // Compare tasks and expected values
   //////////////////////////////////////////////////
   task automatic compare_word(input logic [insn_w-1:0] got, input logic [insn_w-1:0] exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_exc(input fetch_exc_t got, input fetch_exc_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0d ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic compare_tlb(input tlb_word_u got, input tlb_word_u exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got.raw, exp.raw);
      end
   endtask

   // Word index is byte address bits 11:2
   function automatic logic [insn_w-1:0] phys_word(input logic [addr_w-1:0] pa);
      return model[pa[imem_aw+1:2]];
   endfunction

   function automatic tlb_word_u lo_entry(input logic [vpn_w-1:0] vpn, input logic v);
      tlb_word_u w;
      w.raw  = '0;
      w.lo.vpn = vpn;
      w.lo.v   = v;
      return w;
   endfunction

   function automatic tlb_word_u hi_entry(input logic [ppn_w-1:0] ppn, input logic rx,
                                          input logic ux);
      tlb_word_u w;
      w.raw   = '0;
      w.hi.ppn = ppn;
      w.hi.rx  = rx;
      w.hi.ux  = ux;
      w.hi.p   = 1'b1;
      return w;
   endfunction

   //////////////////////////////////////////////////
   // Drivers
   //////////////////////////////////////////////////
   task automatic load_mem(input int n);
      for (int i = 0; i < n; i++) begin
         model[i] = $random(seed);
         imem_wr  = {1'b1, imem_aw'(i), model[i]};
         @(posedge clk);
         #2;
      end
      imem_wr.we = 1'b0;
   endtask

   // Write both words, then read them back once stored
   task automatic write_tlb(input logic [tlb_idx_w-1:0] idx, input tlb_word_u lo,
                            input tlb_word_u hi);
      tlbl_wr = {1'b1, idx, lo.raw};
      tlbh_wr = {1'b1, idx, hi.raw};
      @(posedge clk);
      #2;
      tlbl_wr.we = 1'b0;
      tlbh_wr.we = 1'b0;
      @(posedge clk);
      @(negedge clk);
      compare_tlb(tlbl_rd, lo, "tlbl read-back");
      compare_tlb(tlbh_rd, hi, "tlbh read-back");
      @(posedge clk);
      #2;
   endtask

   // One command, one reply, no back-pressure
   task automatic fetch(input logic [addr_w-1:0] addr, output logic [insn_w-1:0] word,
                        output fetch_exc_t fx);
      int lat;
      cmd_valid  = 1'b1;
      cmd_addr   = addr;
      ibus_ready = 1'b1;
      @(negedge clk);
      while (!cmd_ready) @(negedge clk);
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
      exp_nxt   = addr;
      compare_word(out_id_nxt, exp_nxt, "out_id_nxt after accept");
      // Cycles counted from the accepting edge
      lat = 1;
      @(negedge clk);
      while (!ibus_valid) begin
         lat++;
         @(negedge clk);
      end
      compare_word(32'(lat), 32'd2, "cycles from accept to reply");
      word = ibus_dout;
      fx   = exc;
      @(posedge clk);
      #2;
      exp_id = exp_nxt;
      compare_word(out_id, exp_id, "out_id after reply");
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////
   task automatic untranslated_fetches();
      logic [addr_w-1:0] addrs [4];
      logic [insn_w-1:0] word;
      fetch_exc_t        fx;
      addrs    = '{32'h0000_0000, 32'h0000_0008, 32'h0000_1024, 32'h0000_003c};
      psr.imme = 1'b0;
      psr.rm   = 1'b1;
      foreach (addrs[i]) begin
         fetch(addrs[i], word, fx);
         compare_word(word, phys_word(addrs[i]), "untranslated insn");
         compare_exc(fx, '0, "untranslated flags");
      end
   endtask

   task automatic translated_fetch();
      logic [addr_w-1:0] va;
      tlb_word_u         lo;
      tlb_word_u         hi;
      logic [insn_w-1:0] word;
      fetch_exc_t        fx;
      va = 32'h0004_6010;
      lo = lo_entry(va[addr_w-1:page_shift], 1'b1);
      hi = hi_entry(19'h00055, 1'b1, 1'b1);
      write_tlb(va[page_shift +: tlb_idx_w], lo, hi);
      compare_word(immid, 32'd7, "immid");
      psr.imme = 1'b1;
      psr.rm   = 1'b1;
      fetch(va, word, fx);
      compare_word(word, phys_word({hi.hi.ppn, va[page_shift-1:0]}), "translated insn");
      compare_exc(fx, '0, "translated flags");
   endtask

   // Invalid entry, then a valid entry of another page at the same index
   // Both entries deny execution, so a miss must hide the fault
   task automatic tlb_misses();
      logic [insn_w-1:0] word;
      fetch_exc_t        fx;
      fetch_exc_t        miss;
      miss.tlb_miss   = 1'b1;
      miss.page_fault = 1'b0;
      write_tlb(7'd1, lo_entry(19'd1, 1'b0), hi_entry(19'h00011, 1'b0, 1'b0));
      psr.imme = 1'b1;
      psr.rm   = 1'b1;
      fetch(32'h0000_2008, word, fx);
      compare_exc(fx, miss, "invalid entry flags");
      write_tlb(7'd1, lo_entry(19'd1, 1'b1), hi_entry(19'h00011, 1'b0, 1'b0));
      fetch(32'h0010_2008, word, fx);
      compare_exc(fx, miss, "other vpn flags");
   endtask

   task automatic exec_permissions();
      logic              rx_tab [2];
      logic              ux_tab [2];
      logic [addr_w-1:0] va;
      logic [insn_w-1:0] word;
      fetch_exc_t        fx;
      fetch_exc_t        exp;
      int                pg;
      // Page 2 user only, page 3 privileged only
      rx_tab = '{1'b0, 1'b1};
      ux_tab = '{1'b1, 1'b0};
      write_tlb(7'd2, lo_entry(19'd2, 1'b1), hi_entry(19'h00022, rx_tab[0], ux_tab[0]));
      write_tlb(7'd3, lo_entry(19'd3, 1'b1), hi_entry(19'h00033, rx_tab[1], ux_tab[1]));
      psr.imme = 1'b1;
      for (int k = 0; k < 4; k++) begin
         pg      = k % 2;
         psr.rm  = (k < 2);
         va      = (32'(pg + 2) << page_shift) | 32'h14;
         exp.tlb_miss   = 1'b0;
         exp.page_fault = psr.rm ? !rx_tab[pg] : !ux_tab[pg];
         fetch(va, word, fx);
         compare_exc(fx, exp, "permission flags");
         compare_word(word, phys_word(va), "permission insn");
      end
   endtask

   task automatic stalled_burst();
      logic [addr_w-1:0] addrs [4];
      logic [insn_w-1:0] held;
      logic              held_v;
      logic              acc_cmd;
      logic              acc_rsp;
      logic [addr_w-1:0] acc_addr;
      int                sent;
      int                got;
      int                cyc;
      addrs      = '{32'h2c, 32'h04, 32'h38, 32'h1c};
      psr.imme   = 1'b0;
      sent       = 0;
      got        = 0;
      cyc        = 0;
      held_v     = 1'b0;
      cmd_valid  = 1'b1;
      cmd_addr   = addrs[0];
      ibus_ready = 1'b0;
      while (got < 4) begin
         @(negedge clk);
         acc_cmd  = cmd_valid && cmd_ready;
         acc_rsp  = ibus_valid && ibus_ready;
         acc_addr = cmd_addr;
         // A stalled reply must stay put
         if (held_v && !ibus_valid) begin
            errors++;
            $display("Stalled reply dropped before acceptance at %0d ns", $time);
         end else if (held_v) begin
            compare_word(ibus_dout, held, "stalled reply");
         end
         if (acc_rsp) begin
            compare_word(ibus_dout, phys_word(addrs[got]), "burst reply");
            compare_exc(exc, '0, "burst flags");
            got++;
            held_v = 1'b0;
         end else if (ibus_valid) begin
            held   = ibus_dout;
            held_v = 1'b1;
         end
         @(posedge clk);
         #2;
         // out_id takes the older out_id_nxt
         if (acc_rsp) exp_id = exp_nxt;
         if (acc_cmd) begin
            exp_nxt = acc_addr;
            sent++;
         end
         compare_word(out_id, exp_id, "out_id during burst");
         compare_word(out_id_nxt, exp_nxt, "out_id_nxt during burst");
         cyc++;
         cmd_valid = (sent < 4);
         if (sent < 4) cmd_addr = addrs[sent];
         // Long stall, then one more bubble
         ibus_ready = (cyc >= 6) && (cyc != 9);
      end
      cmd_valid = 1'b0;
   endtask

   // Flush lands as the old reply shows up, with the port stalled
   task automatic flush_redirect();
      logic [addr_w-1:0] target;
      target     = 32'h30;
      psr.imme   = 1'b0;
      ibus_ready = 1'b0;
      cmd_valid  = 1'b1;
      cmd_addr   = 32'h20;
      @(negedge clk);
      while (!cmd_ready) @(negedge clk);
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
      exp_nxt   = 32'h20;
      @(posedge clk);
      #2;
      flush     = 1'b1;
      cmd_valid = 1'b1;
      cmd_addr  = target;
      @(negedge clk);
      if (!cmd_ready) begin
         errors++;
         $display("Flush command with the new target was refused at %0d ns", $time);
      end
      if (ibus_valid) begin
         errors++;
         $display("Old reply reached the fetch port during the flush at %0d ns", $time);
      end
      @(posedge clk);
      #2;
      flush      = 1'b0;
      cmd_valid  = 1'b0;
      ibus_ready = 1'b1;
      exp_id     = target;
      exp_nxt    = target;
      compare_word(out_id_nxt, exp_nxt, "out_id_nxt after flush");
      @(negedge clk);
      while (!ibus_valid) @(negedge clk);
      compare_word(ibus_dout, phys_word(target), "first reply after flush");
      compare_exc(exc, '0, "flags after flush");
      compare_word(out_id, exp_id, "out_id at redirected reply");
      @(posedge clk);
      #2;
      compare_word(out_id, exp_id, "out_id after redirected reply");
   endtask

   initial begin
      seed       = 31;
      errors     = 0;
      checks     = 0;
      rst_n      = 1'b0;
      cmd_valid  = 1'b0;
      cmd_addr   = '0;
      flush      = 1'b0;
      ibus_ready = 1'b0;
      psr        = '0;
      tlbl_wr    = '0;
      tlbh_wr    = '0;
      imem_wr    = '0;
      exp_id     = reset_vector;
      exp_nxt    = reset_vector;
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      load_mem(n_words);
      untranslated_fetches();
      translated_fetch();
      tlb_misses();
      exec_permissions();
      stalled_burst();
      flush_redirect();
      $display("Run complete: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* fetch_top.sv */
// Fetch path top level joining the instruction MMU and the instruction memory
`timescale 1ns/1ps

module fetch_top import immu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic [addr_w-1:0] cmd_addr,
   input  logic              flush,
   output logic              ibus_valid,
   input  logic              ibus_ready,
   output logic [insn_w-1:0] ibus_dout,
   output fetch_exc_t        exc,
   output logic [addr_w-1:0] out_id,
   output logic [addr_w-1:0] out_id_nxt,
   input  psr_t              psr,
   input  tlb_wr_t           tlbl_wr,
   input  tlb_wr_t           tlbh_wr,
   output tlb_word_u         tlbl_rd,
   output tlb_word_u         tlbh_rd,
   output logic [data_w-1:0] immid,
   input  imem_wr_t          imem_wr
);

   // MMU to memory
   logic              mem_cmd_valid;
   logic              mem_cmd_ready;
   logic [addr_w-1:0] mem_cmd_addr;
   logic              mem_valid;
   logic              mem_ready;
   logic [insn_w-1:0] mem_dout;

   immu u_immu (
      .clk           (clk),
      .rst_n         (rst_n),
      .cmd_valid     (cmd_valid),
      .cmd_ready     (cmd_ready),
      .cmd_addr      (cmd_addr),
      .flush         (flush),
      .ibus_valid    (ibus_valid),
      .ibus_ready    (ibus_ready),
      .ibus_dout     (ibus_dout),
      .exc           (exc),
      .out_id        (out_id),
      .out_id_nxt    (out_id_nxt),
      .psr           (psr),
      .tlbl_wr       (tlbl_wr),
      .tlbh_wr       (tlbh_wr),
      .tlbl_rd       (tlbl_rd),
      .tlbh_rd       (tlbh_rd),
      .immid         (immid),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd_addr  (mem_cmd_addr),
      .mem_valid     (mem_valid),
      .mem_ready     (mem_ready),
      .mem_dout      (mem_dout)
   );

   insn_mem u_imem (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (mem_cmd_valid),
      .cmd_ready (mem_cmd_ready),
      .cmd_addr  (mem_cmd_addr),
      .valid     (mem_valid),
      .ready     (mem_ready),
      .dout      (mem_dout),
      .wr        (imem_wr)
   );

endmodule

/* insn_mem.sv */
// Single-cycle instruction memory with one reply register and a load port
`timescale 1ns/1ps

module insn_mem import immu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   // Command
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic [addr_w-1:0] cmd_addr,
   // Reply
   output logic              valid,
   input  logic              ready,
   output logic [insn_w-1:0] dout,
   // Load port
   input  imem_wr_t          wr
);

   logic [insn_w-1:0]  mem [imem_depth];
   logic [insn_w-1:0]  dout_q;
   logic               valid_q;
   logic               hds_cmd;
   logic [imem_aw-1:0] word_addr;

   //////////////////////////////////////////////////
   // Command side
   //////////////////////////////////////////////////
   // Free when empty or the reply leaves this cycle
   assign cmd_ready = ~valid_q | ready;
   assign hds_cmd   = cmd_valid & cmd_ready;

   // Word index from the byte address
   assign word_addr = cmd_addr[imem_aw+1:2];

   // Loads only while no fetch is running
   always_ff @(posedge clk) begin
      if (wr.we) begin
         mem[wr.addr] <= wr.data;
      end
   end

   //////////////////////////////////////////////////
   // Reply register
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         dout_q <= mem[word_addr];
      end
   end

   // Held until taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (hds_cmd) begin
         valid_q <= 1'b1;
      end else if (ready) begin
         valid_q <= 1'b0;
      end
   end

   assign valid = valid_q;
   assign dout  = dout_q;

endmodule

/* immu.sv */
// Instruction MMU: fetch handshake, TLB lookup, execute permission check and flush control
`timescale 1ns/1ps

module immu import immu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   // Fetch command
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic [addr_w-1:0] cmd_addr,
   input  logic              flush,
   // Fetch reply
   output logic              ibus_valid,
   input  logic              ibus_ready,
   output logic [insn_w-1:0] ibus_dout,
   output fetch_exc_t        exc,
   output logic [addr_w-1:0] out_id,
   output logic [addr_w-1:0] out_id_nxt,
   // System registers
   input  psr_t              psr,
   input  tlb_wr_t           tlbl_wr,
   input  tlb_wr_t           tlbh_wr,
   output tlb_word_u         tlbl_rd,
   output tlb_word_u         tlbh_rd,
   output logic [data_w-1:0] immid,
   // Memory side
   output logic              mem_cmd_valid,
   input  logic              mem_cmd_ready,
   output logic [addr_w-1:0] mem_cmd_addr,
   input  logic              mem_valid,
   output logic              mem_ready,
   input  logic [insn_w-1:0] mem_dout
);

   logic                  hds_cmd;
   logic                  hds_mem_cmd;
   logic                  hds_mem_dout;
   logic                  hds_ibus_dout;
   logic                  pipe_ready;
   logic                  cmd_vld_q;
   logic                  pending_q;
   logic                  fls_ok_q;
   logic                  rm_q;
   logic [vpn_w-1:0]      vpn_q;
   logic [page_shift-1:0] off_q;
   logic [addr_w-1:0]     out_id_q;
   logic [addr_w-1:0]     out_id_nxt_q;
   fetch_exc_t            exc_q;
   fetch_exc_t            exc_nxt;
   tlb_word_u             tlb_lo;
   tlb_word_u             tlb_hi;
   logic                  tlb_hit;
   logic                  perm_denied;

   //////////////////////////////////////////////////
   // Handshakes
   //////////////////////////////////////////////////
   // Stage drains when memory takes it, or when flushed
   assign pipe_ready    = ~cmd_vld_q | mem_cmd_ready | flush;
   // No new fetch while a flushed reply is still draining
   assign cmd_ready     = fls_ok_q & pipe_ready;
   assign hds_cmd       = cmd_valid & cmd_ready;
   assign hds_mem_cmd   = mem_cmd_valid & mem_cmd_ready;
   assign hds_mem_dout  = mem_valid & mem_ready;
   assign hds_ibus_dout = ibus_valid & ibus_ready;

   // Waiting command is withdrawn on flush
   assign mem_cmd_valid = cmd_vld_q & ~flush & fls_ok_q;

   // Flushed reply is swallowed here
   assign ibus_valid = mem_valid & fls_ok_q & ~flush;
   assign mem_ready  = ibus_ready | ~fls_ok_q;
   assign ibus_dout  = mem_dout;

   // Translation stage occupancy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_vld_q <= 1'b0;
      end else if (hds_cmd) begin
         cmd_vld_q <= 1'b1;
      end else if (hds_mem_cmd || flush) begin
         cmd_vld_q <= 1'b0;
      end
   end

   // Memory reply outstanding, a new command wins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending_q <= 1'b0;
      end else if (hds_mem_cmd) begin
         pending_q <= 1'b1;
      end else if (hds_mem_dout) begin
         pending_q <= 1'b0;
      end
   end

   // Low while an old reply has to be dropped
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fls_ok_q <= 1'b1;
      end else if (flush && pending_q && !hds_mem_dout) begin
         fls_ok_q <= 1'b0;
      end else if (hds_mem_dout || !pending_q) begin
         fls_ok_q <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Fetch address tracking
   //////////////////////////////////////////////////
   // out_id_nxt follows the TLB, out_id follows the reply port
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_id_nxt_q <= reset_vector;
         out_id_q     <= reset_vector;
      end else begin
         if (hds_cmd) begin
            out_id_nxt_q <= cmd_addr;
         end
         if (flush) begin
            out_id_q <= cmd_addr;
         end else if (hds_ibus_dout) begin
            out_id_q <= out_id_nxt_q;
         end
      end
   end

   assign out_id     = out_id_q;
   assign out_id_nxt = out_id_nxt_q;

   //////////////////////////////////////////////////
   // TLB lookup
   //////////////////////////////////////////////////
   // Offset, page and mode captured with the lookup
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         off_q <= cmd_addr[page_shift-1:0];
         vpn_q <= cmd_addr[addr_w-1:page_shift];
         rm_q  <= psr.rm;
      end
   end

   // Index is the low vpn bits
   tlb_ram tlb_lo_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_en   (hds_cmd),
      .rd_idx  (cmd_addr[page_shift +: tlb_idx_w]),
      .wr      (tlbl_wr),
      .rd_data (tlb_lo),
      .sw_data (tlbl_rd)
   );

   tlb_ram tlb_hi_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_en   (hds_cmd),
      .rd_idx  (cmd_addr[page_shift +: tlb_idx_w]),
      .wr      (tlbh_wr),
      .rd_data (tlb_hi),
      .sw_data (tlbh_rd)
   );

   assign tlb_hit     = tlb_lo.lo.v & (tlb_lo.lo.vpn == vpn_q);
   // rx for privileged mode, ux for user mode
   assign perm_denied = rm_q ? ~tlb_hi.hi.rx : ~tlb_hi.hi.ux;

   // Fault only without a miss, nothing with translation off
   assign exc_nxt.tlb_miss   = psr.imme & ~tlb_hit;
   assign exc_nxt.page_fault = psr.imme & tlb_hit & perm_denied;

   // Flags travel with the memory command
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exc_q <= '0;
      end else if (hds_mem_cmd) begin
         exc_q <= exc_nxt;
      end
   end

   assign exc = exc_q;

   // Physical address, or the virtual one untranslated
   assign mem_cmd_addr = psr.imme ? {tlb_hi.hi.ppn, off_q} : {vpn_q, off_q};

   // TLB size for software
   assign immid = data_w'(tlb_idx_w);

endmodule

/* tlb_ram.sv */
// TLB array with a lookup read port and a software read/write port, with write forwarding
`timescale 1ns/1ps

module tlb_ram import immu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rd_en,
   input  logic [tlb_idx_w-1:0] rd_idx,
   input  tlb_wr_t              wr,
   output tlb_word_u            rd_data,
   output tlb_word_u            sw_data
);

   tlb_word_u mem [tlb_depth];
   tlb_word_u rd_q;
   tlb_word_u sw_q;
   logic      fwd;

   //////////////////////////////////////////////////
   // Software write port
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr.we) begin
         mem[wr.idx] <= wr.data;
      end
   end

   // Write to the entry under lookup this cycle
   assign fwd = wr.we && (wr.idx == rd_idx);

   //////////////////////////////////////////////////
   // Lookup port
   //////////////////////////////////////////////////
   // Cleared so the first lookup word reads as invalid
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_q <= '0;
      end else if (rd_en) begin
         // New word wins over the stored one
         rd_q <= fwd ? wr.data : mem[rd_idx];
      end
   end

   // Read-back for system registers, every cycle
   always_ff @(posedge clk) begin
      if (wr.we) begin
         sw_q <= wr.data;
      end else begin
         sw_q <= mem[wr.idx];
      end
   end

   assign rd_data = rd_q;
   assign sw_data = sw_q;

endmodule

/* immu_pkg.sv */
// Fetch MMU shared widths, processor status bits, TLB word layouts and port records
package immu_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////
   localparam int addr_w     = 32;
   localparam int data_w     = 32;
   localparam int insn_w     = 32;
   // 8 KiB pages
   localparam int page_shift = 13;
   localparam int vpn_w      = addr_w - page_shift;
   localparam int ppn_w      = 19;
   // 128-entry direct-mapped TLB
   localparam int tlb_idx_w  = 7;
   localparam int tlb_depth  = 1 << tlb_idx_w;
   // Instruction memory, word addressed
   localparam int imem_aw    = 10;
   localparam int imem_depth = 1 << imem_aw;
   localparam logic [addr_w-1:0] reset_vector = '0;

   // Status bits seen by fetch
   typedef struct packed {
      logic imme;
      logic rm;
   } psr_t;

   //////////////////////////////////////////////////
   // TLB word layouts
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [vpn_w-1:0] vpn;
      logic [11:0]      rsv;
      logic             v;
   } tlb_lo_t;

   typedef struct packed {
      logic [ppn_w-1:0] ppn;
      logic [3:0]       rsv2;
      logic             s;
      logic [2:0]       rsv1;
      // Privileged / user execute
      logic             rx;
      logic             ux;
      logic [1:0]       rsv0;
      logic             p;
   } tlb_hi_t;

   // Same stored word, meaning set by which array holds it
   typedef union packed {
      logic [data_w-1:0] raw;
      tlb_lo_t           lo;
      tlb_hi_t           hi;
   } tlb_word_u;

   // Software write into one TLB array
   typedef struct packed {
      logic                 we;
      logic [tlb_idx_w-1:0] idx;
      tlb_word_u            data;
   } tlb_wr_t;

   typedef struct packed {
      logic tlb_miss;
      logic page_fault;
   } fetch_exc_t;

   // Load port of the instruction memory
   typedef struct packed {
      logic               we;
      logic [imem_aw-1:0] addr;
      logic [insn_w-1:0]  data;
   } imem_wr_t;

endpackage
